/* all.f */
isa_pkg.sv
pipe_pkg.sv
pipe_ctrl_if.sv
stage_reg.sv
fetch_unit.sv
pipe_control.sv
decode_stage.sv
mult_unit.sv
execute_stage.sv
mycpu_top.sv
tb_clock.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_top

output=$(./obj_dir/Vtb_top) || true
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

/* tb_top.sv */
// ==============================
// testbench for mycpu_top
// memory responder, ISA model
// trace checker and watchdog
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import isa_pkg::*;

    localparam word_t reset_pc       = 32'hbfc0_0000;
    localparam int    clk_period     = 8;
    localparam int    prog_len       = 160;
    localparam int    mem_words      = 256;
    localparam int    worst_cpi      = 50;  // fetch delays plus a full MUL
    localparam int    timeout_cycles = prog_len * worst_cpi + 400;

    logic       aclk;
    logic       reset;
    word_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rvalid;
    logic       rready;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;

    integer seed = 32'hef61;
    word_t  mem [mem_words];
    word_t  exp_pc [$];
    word_t  exp_num [$];
    word_t  exp_data [$];
    bit     taken_target [word_t];  // model branch targets

    // responder and monitor state
    int     ar_wait;
    int     r_wait;
    bit     r_pending;
    word_t  r_addr;
    bit     first_accept = 1'b1;
    word_t  last_accept;
    bit     first_req_seen = 1'b0;
    bit     prev_ar_stall = 1'b0;
    word_t  prev_araddr;

    tb_clock #(.period(clk_period), .reset_cycles(3)) clk_gen (
        .aclk  (aclk),
        .reset (reset)
    );

    mycpu_top #(.reset_pc(reset_pc)) dut_i (
        .aclk              (aclk),
        .reset             (reset),
        .araddr            (araddr),
        .arvalid           (arvalid),
        .arready           (arready),
        .rdata             (rdata),
        .rvalid            (rvalid),
        .rready            (rready),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
    end

    task automatic halt_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        halt_on_failure();
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            halt_on_failure();
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t off;
        off = addr - reset_pc;
        if (off < word_t'(mem_words * 4)) begin
            return mem[int'(off >> 2)];
        end
        return '0;  // zeros past the array
    endfunction

    // random program of the kept subset with forward branches only
    task automatic build_program();
        int        kind;
        int        n;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [15:0] imm;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            kind = rand_below(16);
            rs   = reg_addr_t'(rand_below(8));  // small register set for many dependencies
            rt   = reg_addr_t'(rand_below(8));
            rd   = reg_addr_t'(rand_below(8));
            imm  = 16'(rand_below(65536));
            case (kind)
                0: mem[i] = {6'h00, rs, rt, rd, 5'd0, 6'h21};  // addu
                1: mem[i] = {6'h00, rs, rt, rd, 5'd0, 6'h23};  // subu
                2: mem[i] = {6'h00, rs, rt, rd, 5'd0, 6'h24};
                3: mem[i] = {6'h00, rs, rt, rd, 5'd0, 6'h25};
                4: mem[i] = {6'h00, rs, rt, rd, 5'd0, 6'h26};
                5: mem[i] = {6'h00, rs, rt, rd, 5'd0, 6'h2a};  // slt
                6, 14, 15: mem[i] = {6'h09, rs, rt, imm};      // addiu
                7: mem[i] = {6'h0d, rs, rt, imm};
                8: mem[i] = {6'h0f, 5'd0, rt, imm};
                9, 10: begin
                    n = 1 + rand_below(6);
                    if (i + 1 + n > prog_len) begin
                        n = prog_len - i - 1;
                    end
                    mem[i] = {(kind == 9) ? 6'h04 : 6'h05, rs, rt, 16'(n)};
                end
                11: mem[i] = {6'h1c, rs, rt, rd, 5'd0, 6'h02};  // mul
                12: mem[i] = '0;
                default: mem[i] = {6'h00, rs, rt, rd, 5'd3, 6'h00};  // sll is not in the subset
            endcase
        end
    endtask

    // ISA model without a delay slot
    task automatic run_model();
        word_t     regs [32];
        word_t     pc;
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     sext;
        word_t     val;
        logic [63:0] full;
        reg_addr_t dst;
        bit        wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = reset_pc;
        while (int'((pc - reset_pc) >> 2) < prog_len) begin
            instr = mem[int'((pc - reset_pc) >> 2)];
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            sext  = {{16{instr[15]}}, instr[15:0]};
            wr    = 1'b1;
            dst   = instr[15:11];
            val   = '0;
            case (instr[31:26])
                6'h00: begin
                    case (instr[5:0])
                        6'h21: val = a + b;
                        6'h23: val = a - b;
                        6'h24: val = a & b;
                        6'h25: val = a | b;
                        6'h26: val = a ^ b;
                        6'h2a: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h1c: begin
                    full = {32'd0, a} * {32'd0, b};
                    val  = full[31:0];
                    wr   = (instr[5:0] == 6'h02);
                end
                6'h09: begin
                    dst = instr[20:16];
                    val = a + sext;
                end
                6'h0d: begin
                    dst = instr[20:16];
                    val = a | {16'd0, instr[15:0]};
                end
                6'h0f: begin
                    dst = instr[20:16];
                    val = {instr[15:0], 16'd0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = val;
                exp_pc.push_back(pc);
                exp_num.push_back(word_t'(dst));
                exp_data.push_back(val);
            end
            if ((instr[31:26] == 6'h04 && a == b) || (instr[31:26] == 6'h05 && a != b)) begin
                pc = pc + 32'd4 + {sext[29:0], 2'b00};
                taken_target[pc] = 1'b1;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    // AXI read responder with random arready and rvalid delays
    always @(posedge aclk) begin
        if (reset) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            r_pending = 1'b0;
            ar_wait   = rand_below(4);
        end else begin
            if (rvalid && rready) begin
                rvalid    <= 1'b0;
                r_pending = 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= fetch_word(r_addr);
                end else begin
                    r_wait--;
                end
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                if (first_accept) begin
                    check_value("first araddr", reset_pc, araddr);
                end else if (araddr != last_accept + 32'd4 && !taken_target.exists(araddr)) begin
                    report_failure("fetch request from an address off the program path");
                end
                first_accept = 1'b0;
                last_accept  = araddr;
                r_addr       = araddr;
                r_pending    = 1'b1;
                r_wait       = rand_below(4);
                ar_wait      = rand_below(4);
            end else if (arvalid && !r_pending) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait--;
                end
            end
        end
    end

    // reset, AR stability and trace checks
    always @(posedge aclk) begin
        if (reset && arvalid) begin
            report_failure("arvalid high during reset");
        end
        if (reset && rready) begin
            report_failure("rready high during reset");
        end
        if ((reset || !first_req_seen) && debug_wb_rf_wen != 4'h0) begin
            report_failure("write-back event before the first fetch request");
        end
        if (!reset && arvalid) begin
            first_req_seen = 1'b1;
        end
        if (prev_ar_stall) begin
            if (!arvalid) begin
                report_failure("arvalid dropped before arready");
            end
            check_value("araddr stable", prev_araddr, araddr);
        end
        prev_ar_stall = !reset && arvalid && !arready;
        prev_araddr   = araddr;
        if (!reset && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                report_failure("write-back event with no expected write left");
            end else begin
                check_value("trace wen", 32'hf, word_t'(debug_wb_rf_wen));
                check_value("trace pc", exp_pc.pop_front(), debug_wb_pc);
                check_value("trace wnum", exp_num.pop_front(), word_t'(debug_wb_rf_wnum));
                check_value("trace wdata", exp_data.pop_front(), debug_wb_rf_wdata);
            end
        end
    end

    initial begin
        build_program();
        run_model();
        $display("model expects %0d writes", exp_pc.size());
        wait (reset === 1'b0);
        while (exp_pc.size() != 0) begin
            @(posedge aclk);
        end
        repeat (200) @(posedge aclk);  // no stray writes after the program
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        report_failure("watchdog timeout, trace did not complete in time");
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
// ==============================
// testbench clock and reset
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period       = 8,
    parameter int reset_cycles = 3
) (
    output logic aclk,
    output logic reset
);

    initial begin
        aclk = 1'b0;
        forever #(period / 2) aclk = ~aclk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge aclk);
        reset <= 1'b0;  // released on an edge, synchronous
    end

endmodule

`default_nettype wire

/* mycpu_top.sv */
// ==============================
// CPU top, four-stage pipeline
// AXI read fetch, debug trace ports
// ==============================
`timescale 1ns/1ps
`default_nettype none

module mycpu_top #(
    parameter isa_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  wire                 aclk,
    input  wire                 reset,
    output isa_pkg::word_t      araddr,
    output logic                arvalid,
    input  wire                 arready,
    input  wire isa_pkg::word_t rdata,
    input  wire                 rvalid,
    output logic                rready,
    output isa_pkg::word_t      debug_wb_pc,
    output isa_pkg::word_t      debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output isa_pkg::reg_addr_t  debug_wb_rf_wnum
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t  fetch_pc;
    word_t  fetch_instr;
    if_id_t fetch_data;
    if_id_t id_data;
    logic   id_valid;
    id_ex_t dec_data;
    logic   dec_valid;
    id_ex_t ex_in;
    logic   ex_in_valid;
    ex_wb_t ex_data;
    logic   ex_valid;
    ex_wb_t wb_data;
    logic   wb_valid;

    pipe_ctrl_if ctrl ();

    assign fetch_data = '{pc: fetch_pc, instr: fetch_instr};

    pipe_control u_control (.ctrl(ctrl.control));

    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .aclk        (aclk),
        .reset       (reset),
        .ctrl        (ctrl.fetch),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr)
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .aclk (aclk), .reset (reset), .wr (ctrl.if_id_wr), .flush (ctrl.if_id_flush),
        .in_valid (ctrl.fetch_valid), .in_data (fetch_data),
        .out_valid (id_valid), .out_data (id_data)
    );

    decode_stage u_decode (
        .aclk         (aclk),
        .reset        (reset),
        .in_valid     (id_valid),
        .in_data      (id_data),
        .ex_fwd       (ex_data),   // result still in execute
        .ex_fwd_valid (ex_valid),
        .wb_data      (wb_data),
        .wb_valid     (wb_valid),
        .out_valid    (dec_valid),
        .out_data     (dec_data)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .aclk (aclk), .reset (reset), .wr (ctrl.id_ex_wr), .flush (ctrl.id_ex_flush),
        .in_valid (dec_valid), .in_data (dec_data),
        .out_valid (ex_in_valid), .out_data (ex_in)
    );

    execute_stage u_execute (
        .aclk      (aclk),
        .reset     (reset),
        .ctrl      (ctrl.exec),
        .in_valid  (ex_in_valid),
        .in_data   (ex_in),
        .out_valid (ex_valid),
        .out_data  (ex_data)
    );

    // write-back register always advances
    stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .aclk (aclk), .reset (reset), .wr (1'b1), .flush (ctrl.ex_wb_flush),
        .in_valid (ex_valid), .in_data (ex_data),
        .out_valid (wb_valid), .out_data (wb_data)
    );

    // golden trace
    assign debug_wb_pc       = wb_data.pc;
    assign debug_wb_rf_wdata = wb_data.result;
    assign debug_wb_rf_wnum  = wb_data.dst;
    assign debug_wb_rf_wen   = (wb_valid && wb_data.reg_write && wb_data.dst != '0) ?
                               4'b1111 : 4'b0000;

endmodule

`default_nettype wire

/* execute_stage.sv */
// ==============================
// execute, ALU and branch resolve
// MUL launch and result select
// ==============================
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                     aclk,
    input  wire                     reset,
    pipe_ctrl_if.exec               ctrl,
    input  wire                     in_valid,
    input  wire pipe_pkg::id_ex_t   in_data,
    output logic                    out_valid,
    output pipe_pkg::ex_wb_t        out_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_res;
    word_t product;
    logic  equal;
    logic  is_mul;
    logic  launched;   // multiplier already started for this MUL
    logic  mul_busy;
    logic  mul_wait;

    assign op_a     = in_data.rs_val;
    assign op_b     = in_data.use_imm ? in_data.imm : in_data.rt_val;
    assign equal    = (in_data.rs_val == in_data.rt_val);
    assign is_mul   = in_valid && (in_data.alu_op == alu_mul);
    assign mul_wait = is_mul && (!launched || mul_busy);

    mult_unit u_mult (
        .aclk    (aclk),
        .reset   (reset),
        .start   (is_mul && !launched),
        .a       (in_data.rs_val),
        .b       (in_data.rt_val),
        .busy    (mul_busy),
        .product (product)
    );

    always_ff @(posedge aclk) begin
        if (reset) begin
            launched <= 1'b0;
        end else begin
            launched <= mul_wait;  // drops when the MUL leaves
        end
    end

    always_comb begin
        case (in_data.alu_op)
            alu_add: alu_res = op_a + op_b;
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            alu_slt: alu_res = word_t'($signed(op_a) < $signed(op_b));
            alu_lui: alu_res = {in_data.imm[imm_w-1:0], {(xlen-imm_w){1'b0}}};
            default: alu_res = product;
        endcase
    end

    assign ctrl.mult_busy     = mul_wait;
    assign ctrl.branch_taken  = in_valid &&
                                ((in_data.is_beq && equal) || (in_data.is_bne && !equal));
    assign ctrl.branch_target = in_data.pc + word_t'(4) + {in_data.imm[xlen-3:0], 2'b00};

    assign out_valid          = in_valid;
    assign out_data.pc        = in_data.pc;
    assign out_data.result    = alu_res;
    assign out_data.dst       = in_data.dst;
    assign out_data.reg_write = in_data.reg_write;

endmodule

`default_nettype wire

/* mult_unit.sv */
// ==============================
// shift-add multiplier
// one bit per cycle, low word kept
// ==============================
`timescale 1ns/1ps
`default_nettype none

module mult_unit (
    input  wire                 aclk,
    input  wire                 reset,
    input  wire                 start,
    input  wire isa_pkg::word_t a,
    input  wire isa_pkg::word_t b,
    output logic                busy,
    output isa_pkg::word_t      product
);
    import isa_pkg::*;

    localparam int step_w = $clog2(xlen);

    logic [step_w-1:0] step;  // step counter
    word_t             mcand;
    word_t             mplier;
    word_t             acc;

    always_ff @(posedge aclk) begin
        if (reset) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (&step) begin
                busy <= 1'b0;  // last of xlen steps
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + (mplier[0] ? mcand : '0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

/* decode_stage.sv */
// ==============================
// decode, register file, bypass
// ==============================
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                     aclk,
    input  wire                     reset,
    input  wire                     in_valid,
    input  wire pipe_pkg::if_id_t   in_data,
    input  wire pipe_pkg::ex_wb_t   ex_fwd,
    input  wire                     ex_fwd_valid,
    input  wire pipe_pkg::ex_wb_t   wb_data,
    input  wire                     wb_valid,
    output logic                    out_valid,
    output pipe_pkg::id_ex_t        out_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int rf_depth = 1 << reg_addr_w;

    word_t             rf [rf_depth];
    word_t             instr;
    reg_addr_t         rs;
    reg_addr_t         rt;
    reg_addr_t         rd;
    logic [imm_w-1:0]  imm16;
    logic              wb_write;

    assign instr    = in_data.instr;
    assign rs       = instr[rs_lo +: reg_addr_w];
    assign rt       = instr[rt_lo +: reg_addr_w];
    assign rd       = instr[rd_lo +: reg_addr_w];
    assign imm16    = instr[imm_lo +: imm_w];
    assign wb_write = wb_valid && wb_data.reg_write && (wb_data.dst != '0);

    // execute result first, then write-back, then the file
    function automatic word_t read_operand(input reg_addr_t src);
        word_t value;
        if (src == '0) begin
            value = '0;
        end else if (ex_fwd_valid && ex_fwd.reg_write && ex_fwd.dst == src) begin
            value = ex_fwd.result;
        end else if (wb_write && wb_data.dst == src) begin
            value = wb_data.result;
        end else begin
            value = rf[src];
        end
        return value;
    endfunction

    always_comb begin
        out_data        = '0;
        out_data.pc     = in_data.pc;
        out_data.rs_val = read_operand(rs);
        out_data.rt_val = read_operand(rt);
        out_data.imm    = {{(xlen-imm_w){imm16[imm_w-1]}}, imm16};
        case (opcode_e'(instr[op_lo +: field_w]))
            op_special: begin
                out_data.dst       = rd;
                out_data.reg_write = 1'b1;
                case (funct_e'(instr[funct_lo +: field_w]))
                    fn_addu: out_data.alu_op = alu_add;
                    fn_subu: out_data.alu_op = alu_sub;
                    fn_and:  out_data.alu_op = alu_and;
                    fn_or:   out_data.alu_op = alu_or;
                    fn_xor:  out_data.alu_op = alu_xor;
                    fn_slt:  out_data.alu_op = alu_slt;
                    default: out_data.reg_write = 1'b0;  // retires as nop
                endcase
            end
            op_special2: begin
                out_data.dst       = rd;
                out_data.alu_op    = alu_mul;
                out_data.reg_write = (funct_e'(instr[funct_lo +: field_w]) == fn_mul);
            end
            op_addiu: begin
                out_data.dst       = rt;
                out_data.use_imm   = 1'b1;
                out_data.reg_write = 1'b1;
            end
            op_ori, op_lui: begin
                out_data.imm       = {{(xlen-imm_w){1'b0}}, imm16};  // zero extended
                out_data.dst       = rt;
                out_data.use_imm   = 1'b1;
                out_data.alu_op    = (instr[op_lo +: field_w] == op_lui) ? alu_lui : alu_or;
                out_data.reg_write = 1'b1;
            end
            op_beq: out_data.is_beq = 1'b1;
            op_bne: out_data.is_bne = 1'b1;
            default: ;
        endcase
    end

    assign out_valid = in_valid;

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < rf_depth; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_write) begin
            rf[wb_data.dst] <= wb_data.result;
        end
    end

endmodule

`default_nettype wire

/* pipe_control.sv */
// ==============================
// pipeline stall/flush control
// ==============================
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
    pipe_ctrl_if.control ctrl
);

    always_comb begin
        ctrl.if_id_wr    = 1'b1;
        ctrl.if_id_flush = 1'b0;
        ctrl.id_ex_wr    = 1'b1;
        ctrl.id_ex_flush = 1'b0;
        ctrl.ex_wb_flush = 1'b0;
        ctrl.redirect    = 1'b0;

        if (ctrl.mult_busy) begin
            // front end freezes, bubbles retire behind the MUL
            ctrl.if_id_wr    = 1'b0;
            ctrl.id_ex_wr    = 1'b0;
            ctrl.ex_wb_flush = 1'b1;
        end else if (ctrl.branch_taken) begin
            ctrl.redirect    = 1'b1;
            ctrl.if_id_flush = 1'b1;  // kills fetch output
            ctrl.id_ex_flush = 1'b1;  // kills decode
        end else if (!ctrl.fetch_valid) begin
            ctrl.if_id_flush = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
// ==============================
// fetch unit, PC and AXI read FSM
// discards words after a redirect
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter isa_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  wire                 aclk,
    input  wire                 reset,
    pipe_ctrl_if.fetch          ctrl,
    output isa_pkg::word_t      araddr,
    output logic                arvalid,
    input  wire                 arready,
    input  wire isa_pkg::word_t rdata,
    input  wire                 rvalid,
    output logic                rready,
    output isa_pkg::word_t      fetch_pc,
    output isa_pkg::word_t      fetch_instr
);
    import isa_pkg::*;

    typedef enum logic [2:0] {st_idle, st_addr, st_data, st_hold, st_drain} state_e;

    state_e state;
    word_t  pc;       // address of the word being fetched
    word_t  target;   // restart address while draining
    word_t  instr;
    logic   ar_open;  // drain with AR still unaccepted

    assign araddr           = pc;  // stable through st_addr
    assign arvalid          = (state == st_addr) || (state == st_drain && ar_open);
    assign rready           = (state == st_data) || (state == st_drain && !ar_open);
    assign ctrl.fetch_valid = (state == st_hold);
    assign fetch_pc         = pc;
    assign fetch_instr      = instr;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state   <= st_idle;
            pc      <= reset_pc;
            ar_open <= 1'b0;
        end else begin
            case (state)
                st_idle: state <= st_addr;
                st_addr: begin
                    if (ctrl.redirect) begin
                        state   <= st_drain;
                        ar_open <= !arready;
                    end else if (arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (ctrl.redirect && rvalid) begin  // word dropped on arrival
                        pc    <= ctrl.branch_target;
                        state <= st_addr;
                    end else if (ctrl.redirect) begin
                        state   <= st_drain;
                        ar_open <= 1'b0;
                    end else if (rvalid) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (ctrl.redirect) begin
                        pc    <= ctrl.branch_target;
                        state <= st_addr;
                    end else if (ctrl.if_id_wr) begin
                        pc    <= pc + word_t'(4);
                        state <= st_addr;
                    end
                end
                st_drain: begin
                    if (ar_open) begin
                        ar_open <= !arready;
                    end else if (rvalid) begin
                        pc    <= target;
                        state <= st_addr;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (ctrl.redirect) begin
            target <= ctrl.branch_target;
        end
        if (state == st_data && rvalid) begin
            instr <= rdata;
        end
    end

endmodule

`default_nettype wire

/* stage_reg.sv */
// ==============================
// generic pipeline register
// write enable, flush to bubble
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           aclk,
    input  wire           reset,
    input  wire           wr,
    input  wire           flush,
    input  wire           in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;  // bubble
        end else if (wr) begin
            out_valid <= in_valid;
        end
    end

    // payload only matters when out_valid is set
    always_ff @(posedge aclk) begin
        if (wr) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* pipe_ctrl_if.sv */
// ==============================
// pipeline control interface
// stall, flush and redirect lines
// ==============================
`timescale 1ns/1ps
`default_nettype none

interface pipe_ctrl_if;
    logic           if_id_wr;
    logic           if_id_flush;
    logic           id_ex_wr;
    logic           id_ex_flush;
    logic           ex_wb_flush;
    logic           redirect;      // fetch restarts at branch_target
    logic           fetch_valid;
    logic           branch_taken;
    isa_pkg::word_t branch_target;
    logic           mult_busy;

    modport control (
        input  fetch_valid, branch_taken, mult_busy,
        output if_id_wr, if_id_flush, id_ex_wr, id_ex_flush, ex_wb_flush, redirect
    );
    modport fetch (input if_id_wr, redirect, branch_target, output fetch_valid);
    modport exec (output branch_taken, branch_target, mult_busy);
endinterface

`default_nettype wire

/* pipe_pkg.sv */
// ==============================
// pipeline payload structs
// ALU operation encoding
// ==============================
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui,
        alu_mul  // result comes from the multiplier
    } alu_op_e;

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::word_t    instr;
    } if_id_t;

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::word_t    rs_val;
        isa_pkg::word_t    rt_val;
        isa_pkg::word_t    imm;       // already sign or zero extended
        alu_op_e           alu_op;
        logic              use_imm;   // operand b from imm
        logic              is_beq;
        logic              is_bne;
        isa_pkg::reg_addr_t dst;
        logic              reg_write;
    } id_ex_t;

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::word_t    result;
        isa_pkg::reg_addr_t dst;
        logic              reg_write;
    } ex_wb_t;

endpackage

`default_nettype wire

/* isa_pkg.sv */
// ==============================
// MIPS subset ISA definitions
// widths, opcode/funct codes, field slices
// ==============================
`default_nettype none

package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        op_special  = 6'h00,
        op_beq      = 6'h04,
        op_bne      = 6'h05,
        op_addiu    = 6'h09,
        op_ori      = 6'h0d,
        op_lui      = 6'h0f,
        op_special2 = 6'h1c
    } opcode_e;

    typedef enum logic [5:0] {
        fn_mul  = 6'h02, // only under special2
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    localparam int op_lo    = 26;
    localparam int rs_lo    = 21;
    localparam int rt_lo    = 16;
    localparam int rd_lo    = 11;
    localparam int imm_lo   = 0;
    localparam int imm_w    = 16;
    localparam int funct_lo = 0;
    localparam int field_w  = 6;  // opcode and funct width

endpackage

`default_nettype wire
